/* common/eth_macros.svh */
`ifndef ETH_MACROS_SVH
`define ETH_MACROS_SVH

// Word and lane widths shared by the AXI-stream side and the XGMII side
`define ETH_DATA_WIDTH 32
`define ETH_KEEP_WIDTH 4

// XGMII control characters, sent with the lane's ctrl bit set
`define ETH_XGMII_START 8'hFB
`define ETH_XGMII_TERM 8'hFD
`define ETH_XGMII_IDLE 8'h07

`define ETH_PREAMBLE 8'h55
`define ETH_SFD 8'hD5

// 60 payload bytes before the CRC is appended
`define ETH_MIN_PAYLOAD_WORDS 15
`define ETH_IFG_IDLE_WORDS 3
`define ETH_FIFO_DEPTH 64

`endif

/* common/eth_pkg.sv */
`default_nettype none

`include "eth_macros.svh"

package eth_pkg;

    typedef logic [`ETH_DATA_WIDTH-1:0] xgmii_data_t;
    typedef logic [`ETH_KEEP_WIDTH-1:0] xgmii_ctrl_t;
    typedef logic [`ETH_KEEP_WIDTH-1:0] axis_keep_t;
    typedef logic [31:0] crc_t;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        DATA,
        PADDING,
        CRC,
        TERM,
        IFG
    } tx_state_t;

endpackage

`default_nettype wire

/* common/axis_if.sv */
`timescale 1ns/1ns
`default_nettype none

// One AXI-stream word between the frame buffer and the MAC
interface axis_if;

    eth_pkg::xgmii_data_t tdata;
    eth_pkg::axis_keep_t  tkeep;
    logic                 tvalid;
    logic                 tlast;
    logic                 tready;

    modport source (
        output tdata, tkeep, tvalid, tlast,
        input  tready
    );

    modport sink (
        input  tdata, tkeep, tvalid, tlast,
        output tready
    );

endinterface

`default_nettype wire

/* tx_mac/crc32.sv */
`timescale 1ns/1ns
`default_nettype none

`include "eth_macros.svh"

// IEEE CRC32 over one bus word, lane 0 first, skipping lanes that are not valid
module crc32 (
    input  eth_pkg::crc_t        i_crc_state,
    input  eth_pkg::xgmii_data_t i_data,
    input  eth_pkg::axis_keep_t  i_byte_valid,
    output eth_pkg::crc_t        o_crc_state,
    output eth_pkg::crc_t        o_crc
);

    // Reflected form of 04C11DB7
    localparam eth_pkg::crc_t POLY = 32'hEDB88320;
    localparam int LANES = `ETH_KEEP_WIDTH;

    function automatic eth_pkg::crc_t crc_byte(
        input eth_pkg::crc_t crc,
        input logic [7:0]    data
    );
        eth_pkg::crc_t c;
        c = crc ^ {24'h0, data};
        for (int b = 0; b < 8; b++) begin
            c = c[0] ? ((c >> 1) ^ POLY) : (c >> 1);
        end
        return c;
    endfunction

    function automatic eth_pkg::crc_t crc_word(
        input eth_pkg::crc_t        crc,
        input eth_pkg::xgmii_data_t data,
        input eth_pkg::axis_keep_t  valid
    );
        eth_pkg::crc_t c;
        c = crc;
        for (int lane = 0; lane < LANES; lane++) begin
            if (valid[lane]) begin
                c = crc_byte(c, data[8*lane +: 8]);
            end
        end
        return c;
    endfunction

    assign o_crc_state = crc_word(i_crc_state, i_data, i_byte_valid);

    // The value that goes on the wire, least significant byte first
    assign o_crc = ~o_crc_state;

endmodule

`default_nettype wire

/* tx_mac/tx_mac.sv */
`timescale 1ns/1ns
`default_nettype none

`include "eth_macros.svh"

module tx_mac (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_xgmii_pause,
    axis_if.sink                 s_axis,
    output eth_pkg::xgmii_data_t o_xgmii_txd,
    output eth_pkg::xgmii_ctrl_t o_xgmii_ctrl
);

    localparam int KEEP_W = `ETH_KEEP_WIDTH;
    localparam int CNT_W = $clog2(`ETH_MIN_PAYLOAD_WORDS + 1);
    localparam int IFG_W = $clog2(`ETH_IFG_IDLE_WORDS + 1);
    localparam logic [CNT_W-1:0] MIN_WORDS = CNT_W'(`ETH_MIN_PAYLOAD_WORDS);
    localparam logic [CNT_W-1:0] LAST_PAD_WORD = CNT_W'(`ETH_MIN_PAYLOAD_WORDS - 1);
    localparam logic [IFG_W-1:0] IFG_LAST = IFG_W'(`ETH_IFG_IDLE_WORDS);

    localparam eth_pkg::xgmii_data_t IDLE_WORD = {KEEP_W{`ETH_XGMII_IDLE}};
    localparam eth_pkg::xgmii_data_t START_WORD = {{3{`ETH_PREAMBLE}}, `ETH_XGMII_START};
    localparam eth_pkg::xgmii_data_t PRE_WORD = {`ETH_SFD, {3{`ETH_PREAMBLE}}};
    localparam eth_pkg::xgmii_data_t TERM_WORD = {{3{`ETH_XGMII_IDLE}}, `ETH_XGMII_TERM};
    localparam eth_pkg::xgmii_ctrl_t START_CTRL = 4'b0001;

    eth_pkg::tx_state_t            state;
    eth_pkg::xgmii_data_t          data_lo;
    eth_pkg::xgmii_data_t          data_hi;
    eth_pkg::xgmii_ctrl_t          ctrl_lo;
    eth_pkg::xgmii_ctrl_t          ctrl_hi;
    logic [CNT_W-1:0]              word_cnt;
    logic [IFG_W-1:0]              ifg_cnt;
    logic [2:0]                    last_bytes;
    eth_pkg::crc_t                 crc_state;
    eth_pkg::crc_t                 crc_next;
    eth_pkg::crc_t                 crc_out;
    eth_pkg::xgmii_data_t          masked_data;
    eth_pkg::xgmii_data_t          crc_in_data;
    eth_pkg::axis_keep_t           eff_keep;
    eth_pkg::axis_keep_t           crc_in_valid;
    logic [2*`ETH_DATA_WIDTH-1:0]  tail_src;
    logic [2*`ETH_DATA_WIDTH-1:0]  tail_data;
    logic [2*KEEP_W-1:0]           tail_ctrl;
    logic                          xfer;

    assign s_axis.tready = (state == eth_pkg::DATA);
    assign xfer = s_axis.tvalid && s_axis.tready;

    // Below the minimum length every lane counts, masked ones become pad bytes
    always_comb begin
        eff_keep = (word_cnt < MIN_WORDS) ? '1 : s_axis.tkeep;
        for (int i = 0; i < KEEP_W; i++) begin
            masked_data[8*i +: 8] = s_axis.tkeep[i] ? s_axis.tdata[8*i +: 8] : 8'h00;
        end
    end

    always_comb begin
        crc_in_data  = masked_data;
        crc_in_valid = '0;
        if (state == eth_pkg::DATA && xfer) begin
            crc_in_valid = eff_keep;
        end else if (state == eth_pkg::PADDING) begin
            crc_in_data  = '0;
            crc_in_valid = '1;
        end
    end

    crc32 u_crc32 (
        .i_crc_state  (crc_state),
        .i_data       (crc_in_data),
        .i_byte_valid (crc_in_valid),
        .o_crc_state  (crc_next),
        .o_crc        (crc_out)
    );

    // With no valid lanes the next state equals the current one
    always_ff @(posedge i_clk) begin
        if (state == eth_pkg::IDLE) begin
            crc_state <= '1;
        end else begin
            crc_state <= crc_next;
        end
    end

    // Last word, then CRC bytes, then FD and idles, spread over two words
    always_comb begin
        int nb;
        nb = int'(last_bytes);
        tail_src = {{`ETH_DATA_WIDTH{1'b0}}, data_hi};
        for (int i = 0; i < 2*KEEP_W; i++) begin
            if (i < nb) begin
                tail_data[8*i +: 8] = tail_src[8*i +: 8];
                tail_ctrl[i]        = 1'b0;
            end else if (i < nb + 4) begin
                tail_data[8*i +: 8] = crc_out[8*((i - nb) & 3) +: 8];
                tail_ctrl[i]        = 1'b0;
            end else if (i == nb + 4) begin
                tail_data[8*i +: 8] = `ETH_XGMII_TERM;
                tail_ctrl[i]        = 1'b1;
            end else begin
                tail_data[8*i +: 8] = `ETH_XGMII_IDLE;
                tail_ctrl[i]        = 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state      <= eth_pkg::IDLE;
            data_lo    <= IDLE_WORD;
            data_hi    <= IDLE_WORD;
            ctrl_lo    <= '1;
            ctrl_hi    <= '1;
            word_cnt   <= '0;
            ifg_cnt    <= '0;
            last_bytes <= 3'd4;
        end else begin
            // The low word is on the bus, the high word is next in line
            data_lo <= data_hi;
            ctrl_lo <= ctrl_hi;
            data_hi <= IDLE_WORD;
            ctrl_hi <= '1;
            case (state)
                eth_pkg::IDLE: begin
                    word_cnt <= '0;
                    if (s_axis.tvalid && !i_xgmii_pause) begin
                        data_lo <= START_WORD;
                        ctrl_lo <= START_CTRL;
                        data_hi <= PRE_WORD;
                        ctrl_hi <= '0;
                        state   <= eth_pkg::DATA;
                    end
                end
                eth_pkg::DATA: begin
                    data_hi <= masked_data;
                    ctrl_hi <= '0;
                    if (xfer) begin
                        if (word_cnt != MIN_WORDS) begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                        if (s_axis.tlast) begin
                            last_bytes <= 3'($countones(eff_keep));
                            state <= (word_cnt < LAST_PAD_WORD) ? eth_pkg::PADDING
                                                                : eth_pkg::CRC;
                        end
                    end
                end
                eth_pkg::PADDING: begin
                    data_hi  <= '0;
                    ctrl_hi  <= '0;
                    word_cnt <= word_cnt + 1'b1;
                    if (word_cnt == LAST_PAD_WORD) begin
                        state <= eth_pkg::CRC;
                    end
                end
                eth_pkg::CRC: begin
                    {data_hi, data_lo} <= tail_data;
                    {ctrl_hi, ctrl_lo} <= tail_ctrl;
                    ifg_cnt <= '0;
                    // A full last word leaves no room for FD, so it gets its own word
                    state <= (last_bytes == 3'd4) ? eth_pkg::TERM : eth_pkg::IFG;
                end
                eth_pkg::TERM: begin
                    data_hi <= TERM_WORD;
                    ifg_cnt <= '0;
                    state   <= eth_pkg::IFG;
                end
                eth_pkg::IFG: begin
                    if (ifg_cnt == IFG_LAST) begin
                        state <= eth_pkg::IDLE;
                    end else begin
                        ifg_cnt <= ifg_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= eth_pkg::IDLE;
                end
            endcase
        end
    end

    assign o_xgmii_txd  = data_lo;
    assign o_xgmii_ctrl = ctrl_lo;

    // The buffer only offers complete frames, so a frame never stalls mid-way
    a_gapless_frame: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        s_axis.tready |-> s_axis.tvalid);

    for (genvar g = 0; g < KEEP_W; g++) begin : g_ctrl_chk
        a_ctrl_char: assert property (@(posedge i_clk) disable iff (!i_reset_n)
            o_xgmii_ctrl[g] |-> (o_xgmii_txd[8*g +: 8] inside
                {`ETH_XGMII_START, `ETH_XGMII_TERM, `ETH_XGMII_IDLE}));
    end

endmodule

`default_nettype wire

/* design/tx_frame_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "eth_macros.svh"

module tx_frame_fifo #(
    parameter int DEPTH = `ETH_FIFO_DEPTH
) (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  eth_pkg::xgmii_data_t i_axis_tdata,
    input  eth_pkg::axis_keep_t  i_axis_tkeep,
    input  logic                 i_axis_tvalid,
    input  logic                 i_axis_tlast,
    output logic                 o_axis_tready,
    axis_if.source               m_axis
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    eth_pkg::xgmii_data_t mem_data [DEPTH];
    eth_pkg::axis_keep_t  mem_keep [DEPTH];
    logic                 mem_last [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] word_count;
    logic [CNT_W-1:0] word_count_next;
    logic [CNT_W-1:0] frame_count;
    logic             in_ready;
    logic             wr_en;
    logic             rd_en;

    assign wr_en = i_axis_tvalid && in_ready;
    assign rd_en = m_axis.tvalid && m_axis.tready;

    always_comb begin
        case ({wr_en, rd_en})
            2'b10:   word_count_next = word_count + 1'b1;
            2'b01:   word_count_next = word_count - 1'b1;
            default: word_count_next = word_count;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= i_axis_tdata;
            mem_keep[wr_ptr] <= i_axis_tkeep;
            mem_last[wr_ptr] <= i_axis_tlast;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            word_count  <= '0;
            frame_count <= '0;
            in_ready    <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            word_count <= word_count_next;
            // Ready is registered from the next fill level so it is low in reset
            in_ready   <= (word_count_next != FULL_COUNT);
            case ({wr_en && i_axis_tlast, rd_en && m_axis.tlast})
                2'b10:   frame_count <= frame_count + 1'b1;
                2'b01:   frame_count <= frame_count - 1'b1;
                default: frame_count <= frame_count;
            endcase
        end
    end

    // Words are only offered once a whole frame is stored, so the MAC never starves
    assign m_axis.tvalid = (frame_count != '0) && (word_count != '0);
    assign m_axis.tdata  = mem_data[rd_ptr];
    assign m_axis.tkeep  = mem_keep[rd_ptr];
    assign m_axis.tlast  = mem_last[rd_ptr];
    assign o_axis_tready = in_ready;

    // Equal pointers with words stored mean the buffer is full
    a_no_write_when_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        wr_en |-> !((wr_ptr == rd_ptr) && (word_count != '0)));

    // The MAC only asks for words in the middle of a stored frame
    a_no_read_when_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        m_axis.tready |-> (word_count != '0));

endmodule

`default_nettype wire

/* design/eth_tx_top.sv */
`timescale 1ns/1ns
`default_nettype none

// Frame buffer in front of the transmit MAC, AXI-stream in and XGMII out
module eth_tx_top (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  eth_pkg::xgmii_data_t i_axis_tdata,
    input  eth_pkg::axis_keep_t  i_axis_tkeep,
    input  logic                 i_axis_tvalid,
    input  logic                 i_axis_tlast,
    output logic                 o_axis_tready,
    input  logic                 i_xgmii_pause,
    output eth_pkg::xgmii_data_t o_xgmii_txd,
    output eth_pkg::xgmii_ctrl_t o_xgmii_ctrl
);

    axis_if frame_axis ();

    tx_frame_fifo u_tx_frame_fifo (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_axis_tdata  (i_axis_tdata),
        .i_axis_tkeep  (i_axis_tkeep),
        .i_axis_tvalid (i_axis_tvalid),
        .i_axis_tlast  (i_axis_tlast),
        .o_axis_tready (o_axis_tready),
        .m_axis        (frame_axis.source)
    );

    tx_mac u_tx_mac (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_xgmii_pause (i_xgmii_pause),
        .s_axis        (frame_axis.sink),
        .o_xgmii_txd   (o_xgmii_txd),
        .o_xgmii_ctrl  (o_xgmii_ctrl)
    );

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

// Free running clock for the testbench
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

/* tb/eth_tx_model.svh */
`ifndef ETH_TX_MODEL_SVH
`define ETH_TX_MODEL_SVH

// 32-bit xorshift generator, the state lives in the including module
function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// Bit serial CRC32, LSB of each byte first, reflected polynomial
function automatic logic [31:0] crc_model_byte(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
        fb = c[0] ^ b[i];
        c = c >> 1;
        if (fb) begin
            c = c ^ 32'hEDB88320;
        end
    end
    return c;
endfunction

// Queues one frame as {ctrl, byte} entries, from FB up to FD
function automatic void build_expected(input logic [7:0] payload [$]);
    logic [7:0]  bytes [$];
    logic [31:0] crc;
    bytes = payload;
    while (bytes.size() < 4 * `ETH_MIN_PAYLOAD_WORDS) begin
        bytes.push_back(8'h00);
    end
    exp_q.push_back({1'b1, `ETH_XGMII_START});
    repeat (6) exp_q.push_back({1'b0, `ETH_PREAMBLE});
    exp_q.push_back({1'b0, `ETH_SFD});
    crc = '1;
    foreach (bytes[i]) begin
        crc = crc_model_byte(crc, bytes[i]);
        exp_q.push_back({1'b0, bytes[i]});
    end
    crc = ~crc;
    for (int i = 0; i < 4; i++) begin
        exp_q.push_back({1'b0, crc[8*i +: 8]});
    end
    exp_q.push_back({1'b1, `ETH_XGMII_TERM});
endfunction

`endif

/* tb/eth_tx_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "eth_macros.svh"

module eth_tx_tb;

    localparam int NUM_FRAMES = 20;
    localparam int BP_FIRST = 15;
    localparam int MAX_FRAME_WORDS = 52;
    localparam int MAX_PAUSE = 20;
    // Input words take at most two cycles each, then the gap and the longest pause
    localparam int TIMEOUT_CYCLES =
        NUM_FRAMES * (2 * MAX_FRAME_WORDS + `ETH_IFG_IDLE_WORDS + 1 + MAX_PAUSE) + 500;
    // A full buffer drains in well under four of the longest frames
    localparam int DRAIN_CYCLES = 4 * MAX_FRAME_WORDS;

    logic                 i_clk;
    logic                 i_reset_n;
    eth_pkg::xgmii_data_t i_axis_tdata;
    eth_pkg::axis_keep_t  i_axis_tkeep;
    logic                 i_axis_tvalid;
    logic                 i_axis_tlast;
    logic                 o_axis_tready;
    logic                 i_xgmii_pause;
    eth_pkg::xgmii_data_t o_xgmii_txd;
    eth_pkg::xgmii_ctrl_t o_xgmii_ctrl;

    logic [31:0] rng_state;
    logic [8:0]  exp_q [$];
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          frames_done;
    int          cycle_count;
    int          idle_words;
    int          frame_err_base;
    int          words_in;
    logic        in_frame;
    logic        collect_en;
    logic        pause_q;

    `include "eth_tx_model.svh"

    tb_clock u_tb_clock (.o_clk(i_clk));

    eth_tx_top u_eth_tx_top (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_axis_tdata  (i_axis_tdata),
        .i_axis_tkeep  (i_axis_tkeep),
        .i_axis_tvalid (i_axis_tvalid),
        .i_axis_tlast  (i_axis_tlast),
        .o_axis_tready (o_axis_tready),
        .i_xgmii_pause (i_xgmii_pause),
        .o_xgmii_txd   (o_xgmii_txd),
        .o_xgmii_ctrl  (o_xgmii_ctrl)
    );

    task automatic finish_test(input string name, input int err_base);
        tests_run++;
        if (errors == err_base) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_base);
        end
    endtask

    task automatic check_idle_bus();
        if (o_xgmii_txd !== {4{`ETH_XGMII_IDLE}}) begin
            $display("FAIL o_xgmii_txd expected 0x07070707 got 0x%h", o_xgmii_txd);
            errors++;
        end
        if (o_xgmii_ctrl !== 4'hF) begin
            $display("FAIL o_xgmii_ctrl expected 0xf got 0x%h", o_xgmii_ctrl);
            errors++;
        end
    endtask

    // Walks one bus word lane by lane against the expected byte queue
    task automatic check_bus_word();
        logic [7:0] b;
        logic       c;
        logic [8:0] e;
        logic       all_idle;
        all_idle = 1'b1;
        for (int lane = 0; lane < 4; lane++) begin
            b = o_xgmii_txd[8*lane +: 8];
            c = o_xgmii_ctrl[lane];
            if (in_frame) begin
                all_idle = 1'b0;
                if (exp_q.size() == 0) begin
                    $display("Bus carries frame bytes beyond the expected frames");
                    errors++;
                    in_frame = 1'b0;
                end else begin
                    e = exp_q.pop_front();
                    if (c !== e[8]) begin
                        $display("FAIL o_xgmii_ctrl[%0d] expected 0x%h got 0x%h", lane, e[8], c);
                        errors++;
                    end
                    if (b !== e[7:0]) begin
                        $display("FAIL o_xgmii_txd lane %0d expected 0x%h got 0x%h",
                                 lane, e[7:0], b);
                        errors++;
                    end
                    if (e == {1'b1, `ETH_XGMII_TERM}) begin
                        in_frame = 1'b0;
                        idle_words = 0;
                        finish_test($sformatf("frame %0d", frames_done), frame_err_base);
                        frames_done++;
                    end
                end
            end else if (c === 1'b1 && b === `ETH_XGMII_START) begin
                all_idle = 1'b0;
                frame_err_base = errors;
                if (lane != 0) begin
                    $display("Start character found in lane %0d instead of lane 0", lane);
                    errors++;
                end
                if (pause_q) begin
                    $display("Frame started while pause was high");
                    errors++;
                end
                if (frames_done > 0 && idle_words < `ETH_IFG_IDLE_WORDS) begin
                    $display("Only %0d idle words between frames", idle_words);
                    errors++;
                end
                if (exp_q.size() == 0) begin
                    $display("Frame started with no frame expected");
                    errors++;
                end else begin
                    void'(exp_q.pop_front());
                    in_frame = 1'b1;
                end
            end else if (!(c === 1'b1 && b === `ETH_XGMII_IDLE)) begin
                all_idle = 1'b0;
                $display("FAIL o_xgmii_txd lane %0d expected 0x07 got 0x%h (ctrl %b)", lane, b, c);
                errors++;
            end
        end
        if (all_idle) begin
            idle_words++;
        end
    endtask

    // Drives one frame word by word, masked lanes carry random bytes
    task automatic send_frame(input int len);
        logic [7:0]  payload [$];
        logic [31:0] r;
        int          nwords;
        int          idx;
        for (int i = 0; i < len; i++) begin
            r = next_random();
            payload.push_back(r[7:0]);
        end
        build_expected(payload);
        nwords = (len + 3) / 4;
        for (int w = 0; w < nwords; w++) begin
            r = next_random();
            if (r[1:0] == 2'b00) begin
                i_axis_tvalid = 1'b0;
                @(negedge i_clk);
            end
            r = next_random();
            for (int lane = 0; lane < 4; lane++) begin
                idx = 4 * w + lane;
                i_axis_tkeep[lane] = (idx < len);
                i_axis_tdata[8*lane +: 8] = (idx < len) ? payload[idx] : r[8*lane +: 8];
            end
            i_axis_tvalid = 1'b1;
            i_axis_tlast = (w == nwords - 1);
            while (!o_axis_tready) @(negedge i_clk);
            @(negedge i_clk);
        end
        i_axis_tvalid = 1'b0;
        i_axis_tlast = 1'b0;
    endtask

    // The buffer starts empty and the MAC is paused, so every accepted word stays stored
    task automatic watch_backpressure();
        int base;
        int waited;
        int start_words;
        base = errors;
        waited = 0;
        start_words = words_in;
        while (o_axis_tready && waited < 400) begin
            @(negedge i_clk);
            waited++;
        end
        if (o_axis_tready) begin
            $display("Input ready never went low while pause was held");
            errors++;
        end else if (words_in - start_words != `ETH_FIFO_DEPTH) begin
            $display("Input ready went low after %0d stored words instead of %0d",
                     words_in - start_words, `ETH_FIFO_DEPTH);
            errors++;
        end
        repeat (5) @(negedge i_clk);
        i_xgmii_pause = 1'b0;
        finish_test("back-pressure", base);
    endtask

    always @(posedge i_clk) begin
        pause_q <= i_xgmii_pause;
        cycle_count <= cycle_count + 1;
        if (i_axis_tvalid && o_axis_tready) begin
            words_in <= words_in + 1;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles with %0d frames seen",
                     cycle_count, frames_done);
            $display("Simulation failed");
            $finish;
        end
    end

    always @(negedge i_clk) begin
        if (collect_en) begin
            check_bus_word();
        end
    end

    initial begin
        int          base;
        int          pause_len;
        int          waited;
        logic [31:0] r;
        i_reset_n = 1'b0;
        i_axis_tdata = '0;
        i_axis_tkeep = '0;
        i_axis_tvalid = 1'b0;
        i_axis_tlast = 1'b0;
        i_xgmii_pause = 1'b0;
        rng_state = 32'd9;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        frames_done = 0;
        cycle_count = 0;
        idle_words = 0;
        frame_err_base = 0;
        words_in = 0;
        in_frame = 1'b0;
        collect_en = 1'b0;

        base = errors;
        repeat (2) begin
            @(negedge i_clk);
            check_idle_bus();
            if (o_axis_tready !== 1'b0) begin
                $display("FAIL o_axis_tready expected 0x0 got 0x%h", o_axis_tready);
                errors++;
            end
        end
        i_reset_n = 1'b1;
        collect_en = 1'b1;
        finish_test("reset idle bus", base);

        base = errors;
        repeat (2) @(negedge i_clk);
        if (o_axis_tready !== 1'b1) begin
            $display("FAIL o_axis_tready expected 0x1 got 0x%h", o_axis_tready);
            errors++;
        end
        finish_test("ready after reset", base);

        for (int f = 0; f < BP_FIRST; f++) begin
            r = next_random();
            pause_len = r % (MAX_PAUSE + 1);
            if (pause_len > 0) begin
                i_xgmii_pause = 1'b1;
                repeat (pause_len) @(negedge i_clk);
                i_xgmii_pause = 1'b0;
            end
            r = next_random();
            send_frame(1 + r % 200);
        end

        // Let the first frames leave so the buffer is empty before the pause
        while (frames_done < BP_FIRST) @(negedge i_clk);

        // Long frames behind a held pause overflow the 64 word buffer
        i_xgmii_pause = 1'b1;
        fork
            begin
                for (int f = BP_FIRST; f < NUM_FRAMES; f++) begin
                    r = next_random();
                    send_frame(150 + r % 51);
                end
            end
            watch_backpressure();
        join

        waited = 0;
        while (frames_done < NUM_FRAMES && waited < DRAIN_CYCLES) begin
            @(negedge i_clk);
            waited++;
        end
        base = errors;
        repeat (8) @(negedge i_clk);
        if (frames_done != NUM_FRAMES) begin
            $display("Only %0d of %0d frames reached the bus", frames_done, NUM_FRAMES);
            errors++;
        end
        finish_test("all frames delivered", base);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+common
+incdir+tb
common/eth_pkg.sv
common/axis_if.sv
tx_mac/crc32.sv
tx_mac/tx_mac.sv
design/tx_frame_fifo.sv
design/eth_tx_top.sv
tb/tb_clock.sv
tb/eth_tx_tb.sv

/* Makefile */
# Verilator build and run for the 10G Ethernet transmit subsystem

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f src.f --top-module eth_tx_tb -o eth_tx_sim
	./obj_dir/eth_tx_sim | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
